/* hdl/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

////////////////////////////////////////////////////////////
// Core-wide constants
////////////////////////////////////////////////////////////

// First fetch address after reset
`define RESET_PC 32'h0000_3000

// Data memory depth in 32-bit words (4 KiB)
`define DM_WORDS 1024

// General purpose register count
`define NUM_REGS 32

`endif

/* hdl/isaPkg.sv */
package isaPkg;

    ////////////////////////////////////////////////////////////
    // Field types
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    ////////////////////////////////////////////////////////////
    // Primary opcodes
    ////////////////////////////////////////////////////////////

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    // Function codes under OP_SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

/* hdl/ctrlPkg.sv */
package ctrlPkg;

    ////////////////////////////////////////////////////////////
    // Decoded control fields
    ////////////////////////////////////////////////////////////

    // Destination register select
    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_RA
    } regDst_t;

    // Second ALU operand. Shifts also take rt as the first one
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_SHAMT
    } aluSrc_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLT,
        SLL
    } aluOp_t;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK,
        WB_LUI
    } memToReg_t;

    typedef enum logic [1:0] {
        NPC_SEQ,
        NPC_BRANCH,
        NPC_JUMP,
        NPC_JREG
    } npcOp_t;

    typedef enum logic [1:0] { CMP_EQ, CMP_NE } cmpOp_t;
    typedef enum logic [1:0] { DM_WORD, DM_HALF, DM_BYTE } dmWidth_t;
    typedef enum logic [1:0] { EXT_ZERO, EXT_SIGN } extOp_t;

endpackage

/* hdl/ctrl.sv */
module ctrl (
    input  isaPkg::word_t       instr,
    output ctrlPkg::regDst_t    regDst,
    output logic                regWrite,
    output ctrlPkg::extOp_t     extOp,
    output ctrlPkg::aluSrc_t    aluSrc,
    output ctrlPkg::aluOp_t     aluOp,
    output logic                memWrite,
    output ctrlPkg::memToReg_t  memToReg,
    output ctrlPkg::npcOp_t     npcOp,
    output ctrlPkg::cmpOp_t     cmpOp,
    output ctrlPkg::dmWidth_t   dmWidth
);

    isaPkg::opcode_t op;
    isaPkg::funct_t  fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        // Anything not listed falls through as a no-op
        regDst   = ctrlPkg::DST_RT;
        regWrite = 1'b0;
        extOp    = ctrlPkg::EXT_SIGN;
        aluSrc   = ctrlPkg::SRC_REG;
        aluOp    = ctrlPkg::ADD;
        memWrite = 1'b0;
        memToReg = ctrlPkg::WB_ALU;
        npcOp    = ctrlPkg::NPC_SEQ;
        cmpOp    = ctrlPkg::CMP_EQ;
        dmWidth  = ctrlPkg::DM_WORD;

        case (op)
            isaPkg::OP_SPECIAL: begin
                regDst = ctrlPkg::DST_RD;
                case (fn)
                    isaPkg::FN_ADDU: begin
                        regWrite = 1'b1;
                        aluOp    = ctrlPkg::ADD;
                    end
                    isaPkg::FN_SUBU: begin
                        regWrite = 1'b1;
                        aluOp    = ctrlPkg::SUB;
                    end
                    isaPkg::FN_AND: begin
                        regWrite = 1'b1;
                        aluOp    = ctrlPkg::AND;
                    end
                    isaPkg::FN_OR: begin
                        regWrite = 1'b1;
                        aluOp    = ctrlPkg::OR;
                    end
                    isaPkg::FN_SLT: begin
                        regWrite = 1'b1;
                        aluOp    = ctrlPkg::SLT;
                    end
                    isaPkg::FN_SLL: begin
                        regWrite = 1'b1;
                        aluSrc   = ctrlPkg::SRC_SHAMT;
                        aluOp    = ctrlPkg::SLL;
                    end
                    isaPkg::FN_JR:   npcOp = ctrlPkg::NPC_JREG;
                    default: ;
                endcase
            end
            isaPkg::OP_ORI: begin
                regWrite = 1'b1;
                extOp    = ctrlPkg::EXT_ZERO;
                aluSrc   = ctrlPkg::SRC_IMM;
                aluOp    = ctrlPkg::OR;
            end
            isaPkg::OP_ADDIU: begin
                regWrite = 1'b1;
                aluSrc   = ctrlPkg::SRC_IMM;
            end
            isaPkg::OP_LUI: begin
                regWrite = 1'b1;
                memToReg = ctrlPkg::WB_LUI;
            end
            // Loads and stores share the base + offset address path
            isaPkg::OP_LW, isaPkg::OP_LH, isaPkg::OP_LB: begin
                regWrite = 1'b1;
                aluSrc   = ctrlPkg::SRC_IMM;
                memToReg = ctrlPkg::WB_MEM;
                dmWidth  = (op == isaPkg::OP_LW) ? ctrlPkg::DM_WORD :
                           (op == isaPkg::OP_LH) ? ctrlPkg::DM_HALF : ctrlPkg::DM_BYTE;
            end
            isaPkg::OP_SW, isaPkg::OP_SH, isaPkg::OP_SB: begin
                memWrite = 1'b1;
                aluSrc   = ctrlPkg::SRC_IMM;
                dmWidth  = (op == isaPkg::OP_SW) ? ctrlPkg::DM_WORD :
                           (op == isaPkg::OP_SH) ? ctrlPkg::DM_HALF : ctrlPkg::DM_BYTE;
            end
            isaPkg::OP_BEQ: npcOp = ctrlPkg::NPC_BRANCH;
            isaPkg::OP_BNE: begin
                npcOp = ctrlPkg::NPC_BRANCH;
                cmpOp = ctrlPkg::CMP_NE;
            end
            isaPkg::OP_J: npcOp = ctrlPkg::NPC_JUMP;
            isaPkg::OP_JAL: begin
                npcOp    = ctrlPkg::NPC_JUMP;
                regWrite = 1'b1;
                regDst   = ctrlPkg::DST_RA;
                memToReg = ctrlPkg::WB_LINK;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/ifu.sv */
`include "cpu_defs.svh"

module ifu (
    input  logic             clk,
    input  logic             rstN,
    input  isaPkg::word_t    instr,
    input  ctrlPkg::npcOp_t  npcOp,
    input  ctrlPkg::cmpOp_t  cmpOp,
    input  isaPkg::word_t    rd1,
    input  isaPkg::word_t    rd2,
    output isaPkg::word_t    pc
);

    isaPkg::word_t pcPlus4;
    isaPkg::word_t npc;
    isaPkg::imm_t  offset;
    logic          taken;

    assign pcPlus4 = pc + 32'd4;
    assign offset  = instr[15:0];

    // Branch comparator
    assign taken = (cmpOp == ctrlPkg::CMP_NE) ? (rd1 != rd2) : (rd1 == rd2);

    always_comb begin
        case (npcOp)
            ctrlPkg::NPC_BRANCH:
                npc = taken ? pcPlus4 + {{14{offset[15]}}, offset, 2'b00} : pcPlus4;
            ctrlPkg::NPC_JUMP: npc = {pcPlus4[31:28], instr[25:0], 2'b00};
            ctrlPkg::NPC_JREG: npc = rd1;
            default:           npc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= npc;
        end
    end

endmodule

/* hdl/grf.sv */
`include "cpu_defs.svh"

module grf (
    input  logic              clk,
    input  logic              rstN,
    input  logic              regWrite,
    input  isaPkg::regAddr_t  ra1,
    input  isaPkg::regAddr_t  ra2,
    input  isaPkg::regAddr_t  wa,
    input  isaPkg::word_t     wd,
    output isaPkg::word_t     rd1,
    output isaPkg::word_t     rd2,
    output logic              regWe,
    output isaPkg::regAddr_t  regWaddr,
    output isaPkg::word_t     regWdata
);

    isaPkg::word_t regs [`NUM_REGS];

    // $0 is never written, so it stays at its reset value of zero
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    // No commit while held in reset or for writes aimed at $0
    assign regWe    = regWrite && (wa != '0) && rstN;
    assign regWaddr = wa;
    assign regWdata = wd;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe) begin
            regs[wa] <= wd;
        end
    end

endmodule

/* hdl/execute.sv */
module execute (
    input  isaPkg::word_t     instr,
    input  isaPkg::word_t     rd1,
    input  isaPkg::word_t     rd2,
    input  ctrlPkg::extOp_t   extOp,
    input  ctrlPkg::aluSrc_t  aluSrc,
    input  ctrlPkg::aluOp_t   aluOp,
    output isaPkg::word_t     aluResult
);

    isaPkg::imm_t  imm;
    isaPkg::word_t extImm;
    isaPkg::word_t srcA;
    isaPkg::word_t srcB;
    logic [4:0]    shamt;

    assign imm   = instr[15:0];
    assign shamt = instr[10:6];

    ////////////////////////////////////////////////////////////
    // Immediate extension
    ////////////////////////////////////////////////////////////

    assign extImm = (extOp == ctrlPkg::EXT_SIGN) ? {{16{imm[15]}}, imm} : {16'h0000, imm};

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    // Shifts take rt as the value and shamt as the distance
    assign srcA = (aluSrc == ctrlPkg::SRC_SHAMT) ? rd2 : rd1;

    always_comb begin
        case (aluSrc)
            ctrlPkg::SRC_IMM:   srcB = extImm;
            ctrlPkg::SRC_SHAMT: srcB = {27'd0, shamt};
            default:            srcB = rd2;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            ctrlPkg::SUB: aluResult = srcA - srcB;
            ctrlPkg::AND: aluResult = srcA & srcB;
            ctrlPkg::OR:  aluResult = srcA | srcB;
            // Signed compare
            ctrlPkg::SLT: aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            ctrlPkg::SLL: aluResult = srcA << srcB[4:0];
            default:      aluResult = srcA + srcB;
        endcase
    end

endmodule

/* hdl/dm.sv */
`include "cpu_defs.svh"

module dm (
    input  logic               clk,
    input  logic               rstN,
    input  logic               memWrite,
    input  ctrlPkg::dmWidth_t  dmWidth,
    input  isaPkg::word_t      addr,
    input  isaPkg::word_t      wdata,
    output isaPkg::word_t      rdata,
    output logic               memWe,
    output isaPkg::word_t      memAddr,
    output isaPkg::word_t      memWdata
);

    localparam int IDX_W = $clog2(`DM_WORDS);

    isaPkg::word_t mem [`DM_WORDS];
    logic [IDX_W-1:0] idx;
    isaPkg::word_t word;
    logic [15:0] half;
    logic [7:0]  byteLane;

    // Low address bits pick the lane only, misalignment is ignored
    assign idx      = addr[IDX_W+1:2];
    assign word     = mem[idx];
    assign half     = addr[1] ? word[31:16] : word[15:0];
    assign byteLane = word[8*addr[1:0] +: 8];

    always_comb begin
        case (dmWidth)
            ctrlPkg::DM_HALF: begin
                rdata    = {{16{half[15]}}, half};
                memAddr  = {addr[31:1], 1'b0};
                memWdata = word;
                memWdata[16*addr[1] +: 16] = wdata[15:0];
            end
            ctrlPkg::DM_BYTE: begin
                rdata    = {{24{byteLane[7]}}, byteLane};
                memAddr  = addr;
                memWdata = word;
                memWdata[8*addr[1:0] +: 8] = wdata[7:0];
            end
            default: begin
                rdata    = word;
                memAddr  = {addr[31:2], 2'b00};
                memWdata = wdata;
            end
        endcase
    end

    assign memWe = memWrite && rstN;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `DM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (memWe) begin
            mem[idx] <= memWdata;
        end
    end

endmodule

/* hdl/mips.sv */
module mips (
    input  logic              clk,
    input  logic              rstN,
    input  isaPkg::word_t     instr,
    output isaPkg::word_t     pc,
    output logic              regWe,
    output isaPkg::regAddr_t  regWaddr,
    output isaPkg::word_t     regWdata,
    output logic              memWe,
    output isaPkg::word_t     memAddr,
    output isaPkg::word_t     memWdata
);

    ctrlPkg::regDst_t   regDst;
    logic               regWrite;
    ctrlPkg::extOp_t    extOp;
    ctrlPkg::aluSrc_t   aluSrc;
    ctrlPkg::aluOp_t    aluOp;
    logic               memWrite;
    ctrlPkg::memToReg_t memToReg;
    ctrlPkg::npcOp_t    npcOp;
    ctrlPkg::cmpOp_t    cmpOp;
    ctrlPkg::dmWidth_t  dmWidth;

    isaPkg::regAddr_t wa;
    isaPkg::word_t    wd;
    isaPkg::word_t    rd1;
    isaPkg::word_t    rd2;
    isaPkg::word_t    aluResult;
    isaPkg::word_t    rdata;
    isaPkg::imm_t     imm;

    assign imm = instr[15:0];

    ctrl ctrl0 (
        .instr(instr), .regDst(regDst), .regWrite(regWrite), .extOp(extOp),
        .aluSrc(aluSrc), .aluOp(aluOp), .memWrite(memWrite), .memToReg(memToReg),
        .npcOp(npcOp), .cmpOp(cmpOp), .dmWidth(dmWidth)
    );

    ifu ifu0 (
        .clk(clk), .rstN(rstN), .instr(instr), .npcOp(npcOp), .cmpOp(cmpOp),
        .rd1(rd1), .rd2(rd2), .pc(pc)
    );

    // Destination register
    always_comb begin
        case (regDst)
            ctrlPkg::DST_RD: wa = instr[15:11];
            ctrlPkg::DST_RA: wa = 5'd31;
            default:         wa = instr[20:16];
        endcase
    end

    grf grf0 (
        .clk(clk), .rstN(rstN), .regWrite(regWrite), .ra1(instr[25:21]),
        .ra2(instr[20:16]), .wa(wa), .wd(wd), .rd1(rd1), .rd2(rd2),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata)
    );

    execute execute0 (
        .instr(instr), .rd1(rd1), .rd2(rd2), .extOp(extOp), .aluSrc(aluSrc),
        .aluOp(aluOp), .aluResult(aluResult)
    );

    dm dm0 (
        .clk(clk), .rstN(rstN), .memWrite(memWrite), .dmWidth(dmWidth),
        .addr(aluResult), .wdata(rd2), .rdata(rdata), .memWe(memWe),
        .memAddr(memAddr), .memWdata(memWdata)
    );

    // Write-back select where link carries the return address
    always_comb begin
        case (memToReg)
            ctrlPkg::WB_MEM:  wd = rdata;
            ctrlPkg::WB_LINK: wd = pc + 32'd4;
            ctrlPkg::WB_LUI:  wd = {imm, 16'h0000};
            default:          wd = aluResult;
        endcase
    end

endmodule

/* bench/clkGen.sv */
module clkGen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset drops just after a rising edge
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

/* bench/mipsTb.sv */
`include "cpu_defs.svh"

module mipsTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTRS     = 2000;
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = NUM_INSTRS + RESET_CYCLES + 100;

    logic             clk;
    logic             rstN;
    isaPkg::word_t    instr;
    isaPkg::word_t    pc;
    logic             regWe;
    isaPkg::regAddr_t regWaddr;
    isaPkg::word_t    regWdata;
    logic             memWe;
    isaPkg::word_t    memAddr;
    isaPkg::word_t    memWdata;

    // ISA model state and a register file rebuilt from DUT commits
    isaPkg::word_t modelRegs [`NUM_REGS];
    isaPkg::word_t seenRegs  [`NUM_REGS];
    isaPkg::word_t modelMem  [`DM_WORDS];
    isaPkg::word_t modelPc;

    logic             expRegWe;
    isaPkg::regAddr_t expRegWaddr;
    isaPkg::word_t    expRegWdata;
    logic             expMemWe;
    isaPkg::word_t    expMemAddr;
    isaPkg::word_t    expMemWdata;

    logic [31:0] seed    = 32'hdbd8;
    logic        jalSeen = 1'b0;
    int          errors  = 0;
    int          checks  = 0;
    int          cycles  = 0;

    clkGen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clkGen0 (.clk(clk), .rstN(rstN));

    mips dut0 (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
        .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata)
    );

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic writeReg(input isaPkg::regAddr_t dst, input isaPkg::word_t val);
        // Writes to $0 vanish
        if (dst != 5'd0) begin
            expRegWe       = 1'b1;
            expRegWaddr    = dst;
            expRegWdata    = val;
            modelRegs[dst] = val;
        end
    endtask

    task automatic storeWord(input isaPkg::word_t addr, input isaPkg::word_t val);
        expMemWe               = 1'b1;
        expMemAddr             = addr;
        expMemWdata            = val;
        modelMem[addr[11:2]]   = val;
    endtask

    // Registers stay within $0..$7 so results feed later instructions
    function automatic isaPkg::word_t genInstr();
        logic [31:0]      r;
        logic [31:0]      v;
        isaPkg::regAddr_t rs;
        isaPkg::regAddr_t rt;
        isaPkg::regAddr_t rd;
        logic [15:0]      off;
        int               kind;
        r    = nextRand();
        v    = nextRand();
        kind = int'(nextRand() >> 16) % 20;
        rs   = {2'b00, r[31:29]};
        rt   = {2'b00, r[28:26]};
        rd   = {2'b00, r[25:23]};
        off  = r[22] ? {4'h0, v[27:16]} : {8'h00, v[23:16]};
        if (kind == 19 && !jalSeen) begin
            kind = 0;
        end
        if (kind == 18) begin
            jalSeen = 1'b1;
        end
        // Unaligned offsets exercise the dropped low address bits
        case (kind)
            0:  return {isaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, isaPkg::FN_ADDU};
            1:  return {isaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, isaPkg::FN_SUBU};
            2:  return {isaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, isaPkg::FN_AND};
            3:  return {isaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, isaPkg::FN_OR};
            4:  return {isaPkg::OP_SPECIAL, rs, rt, rd, 5'd0, isaPkg::FN_SLT};
            5:  return {isaPkg::OP_SPECIAL, 5'd0, rt, rd, v[10:6], isaPkg::FN_SLL};
            6:  return {isaPkg::OP_ORI, rs, rt, v[31:16]};
            7:  return {isaPkg::OP_ADDIU, rs, rt, v[31:16]};
            8:  return {isaPkg::OP_LUI, 5'd0, rt, v[31:16]};
            9:  return {isaPkg::OP_LW, 5'd0, rt, off};
            10: return {isaPkg::OP_LH, 5'd0, rt, off};
            11: return {isaPkg::OP_LB, 5'd0, rt, off};
            12: return {isaPkg::OP_SW, 5'd0, rt, off};
            13: return {isaPkg::OP_SH, 5'd0, rt, off};
            14: return {isaPkg::OP_SB, 5'd0, rt, off};
            15: return {isaPkg::OP_BEQ, rs, rt, v[31:16]};
            16: return {isaPkg::OP_BNE, rs, rt, v[31:16]};
            17: return {isaPkg::OP_J, v[31:6]};
            18: return {isaPkg::OP_JAL, v[31:6]};
            default: return {isaPkg::OP_SPECIAL, 5'd31, 15'd0, isaPkg::FN_JR};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // ISA reference model stepping one instruction per call
    ////////////////////////////////////////////////////////////

    task automatic runModel(input isaPkg::word_t ins);
        isaPkg::word_t a;
        isaPkg::word_t b;
        isaPkg::word_t sImm;
        isaPkg::word_t addr;
        isaPkg::word_t old;
        isaPkg::word_t lane;
        isaPkg::word_t link;
        isaPkg::word_t nextPc;
        logic [4:0]    bsh;
        logic [4:0]    hsh;
        a           = modelRegs[ins[25:21]];
        b           = modelRegs[ins[20:16]];
        sImm        = {{16{ins[15]}}, ins[15:0]};
        addr        = a + sImm;
        old         = modelMem[addr[11:2]];
        link        = modelPc + 32'd4;
        nextPc      = link;
        bsh         = {addr[1:0], 3'b000};
        hsh         = {addr[1], 4'b0000};
        expRegWe    = 1'b0;
        expRegWaddr = '0;
        expRegWdata = '0;
        expMemWe    = 1'b0;
        expMemAddr  = '0;
        expMemWdata = '0;
        case (ins[31:26])
            isaPkg::OP_SPECIAL: begin
                case (ins[5:0])
                    isaPkg::FN_ADDU: writeReg(ins[15:11], a + b);
                    isaPkg::FN_SUBU: writeReg(ins[15:11], a - b);
                    isaPkg::FN_AND:  writeReg(ins[15:11], a & b);
                    isaPkg::FN_OR:   writeReg(ins[15:11], a | b);
                    isaPkg::FN_SLT:  writeReg(ins[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
                    isaPkg::FN_SLL:  writeReg(ins[15:11], b << ins[10:6]);
                    isaPkg::FN_JR:   nextPc = a;
                    default: ;
                endcase
            end
            isaPkg::OP_ORI:   writeReg(ins[20:16], a | {16'h0000, ins[15:0]});
            isaPkg::OP_ADDIU: writeReg(ins[20:16], a + sImm);
            isaPkg::OP_LUI:   writeReg(ins[20:16], {ins[15:0], 16'h0000});
            isaPkg::OP_LW:    writeReg(ins[20:16], old);
            isaPkg::OP_LH: begin
                lane = old >> hsh;
                writeReg(ins[20:16], {{16{lane[15]}}, lane[15:0]});
            end
            isaPkg::OP_LB: begin
                lane = old >> bsh;
                writeReg(ins[20:16], {{24{lane[7]}}, lane[7:0]});
            end
            isaPkg::OP_SW: storeWord({addr[31:2], 2'b00}, b);
            isaPkg::OP_SH: storeWord({addr[31:1], 1'b0},
                (old & ~(32'h0000ffff << hsh)) | ((b & 32'h0000ffff) << hsh));
            isaPkg::OP_SB: storeWord(addr,
                (old & ~(32'h000000ff << bsh)) | ((b & 32'h000000ff) << bsh));
            isaPkg::OP_BEQ: begin
                if (a == b) nextPc = link + (sImm << 2);
            end
            isaPkg::OP_BNE: begin
                if (a != b) nextPc = link + (sImm << 2);
            end
            isaPkg::OP_J: nextPc = {link[31:28], ins[25:0], 2'b00};
            isaPkg::OP_JAL: begin
                writeReg(5'd31, link);
                nextPc = {link[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
        modelPc = nextPc;
    endtask

    ////////////////////////////////////////////////////////////
    // Run
    ////////////////////////////////////////////////////////////

    initial begin
        instr   = {isaPkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234};
        modelPc = `RESET_PC;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
            seenRegs[i]  = '0;
        end
        for (int i = 0; i < `DM_WORDS; i++) begin
            modelMem[i] = '0;
        end

        // Register and memory writes offered while in reset
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge clk);
            #1;
            instr = i[0] ? {isaPkg::OP_SW, 5'd0, 5'd1, 16'h0040}
                         : {isaPkg::OP_ADDIU, 5'd0, 5'd1, 16'h1234};
            @(negedge clk);
            checkValue("pc", pc, `RESET_PC);
            checkValue("regWe", 32'(regWe), 32'd0);
            checkValue("memWe", 32'(memWe), 32'd0);
        end

        for (int n = 0; n < NUM_INSTRS; n++) begin
            @(posedge clk);
            #1;
            instr = genInstr();
            @(negedge clk);
            if (rstN !== 1'b1) begin
                errors++;
                $display("Reset still asserted in program cycle %0d", n);
            end
            checkValue("pc", pc, modelPc);
            runModel(instr);
            checkValue("regWe", 32'(regWe), 32'(expRegWe));
            if (expRegWe) begin
                checkValue("regWaddr", 32'(regWaddr), 32'(expRegWaddr));
                checkValue("regWdata", regWdata, expRegWdata);
            end
            checkValue("memWe", 32'(memWe), 32'(expMemWe));
            if (expMemWe) begin
                checkValue("memAddr", memAddr, expMemAddr);
                checkValue("memWdata", memWdata, expMemWdata);
            end
            if (regWe === 1'b1) begin
                seenRegs[regWaddr] = regWdata;
            end
        end
        @(posedge clk);

        // Register file seen through commits against the model
        for (int i = 0; i < `NUM_REGS; i++) begin
            checkValue($sformatf("reg[%0d]", i), seenRegs[i], modelRegs[i]);
        end

        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, program did not finish", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/ctrl.sv
hdl/ifu.sv
hdl/grf.sv
hdl/execute.sv
hdl/dm.sv
hdl/mips.sv
bench/clkGen.sv
bench/mipsTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the mipsTb testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module mipsTb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VmipsTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Any failure report in the log fails the run
if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0
